// File: logic/dmem_wb_settings.svh
// --------------------
// Bridge build settings
// Bus width, byte lanes and request FIFO depth
// --------------------
`ifndef DMEM_WB_SETTINGS_SVH
`define DMEM_WB_SETTINGS_SVH

// Data and address width
// Same on the core port and the Wishbone side
`define DMEM_WB_DATA_W 32

// Byte lanes on the bus, one select bit each
`define DMEM_WB_SEL_W 4

// Request FIFO depth for the registered variant
// Two entries keep the bus busy across one wait state
`define DMEM_WB_FIFO_DEPTH 2

`endif

// File: logic/dmem_core_pkg.sv
// --------------------
// Core data-memory port types
// Command, width and response encodings plus the request bundle
// --------------------
`include "dmem_wb_settings.svh"

package dmem_core_pkg;

    // --------------------
    // Encodings
    // --------------------

    // Access direction
    typedef enum logic {
        MEM_CMD_RD = 1'b0,
        MEM_CMD_WR = 1'b1
    } mem_cmd_e;

    // Access width requested by the core
    // Code 2'b11 is unused and handled as a word
    typedef enum logic [1:0] {
        MEM_WIDTH_BYTE  = 2'b00,
        MEM_WIDTH_HWORD = 2'b01,
        MEM_WIDTH_WORD  = 2'b10
    } mem_width_e;

    // Response seen by the core, valid for one cycle
    typedef enum logic [1:0] {
        MEM_RESP_NOTRDY = 2'b00,
        MEM_RESP_RDY_OK = 2'b01,
        MEM_RESP_RDY_ER = 2'b10
    } mem_resp_e;

    // --------------------
    // Request bundle
    // --------------------

    // Command, width, address and unaligned write data
    typedef struct packed {
        mem_cmd_e                   cmd;
        mem_width_e                 width;
        logic [`DMEM_WB_DATA_W-1:0] addr;
        logic [`DMEM_WB_DATA_W-1:0] wdata;
    } dmem_req_s;

endpackage

// File: logic/dmem_wb_pkg.sv
// --------------------
// Wishbone side types
// Access size, bus request, response context and FIFO entry
// --------------------
`include "dmem_wb_settings.svh"

package dmem_wb_pkg;

    // Bits needed for the byte offset inside a bus word
    localparam int WB_OFFS_W = $clog2(`DMEM_WB_SEL_W);

    // --------------------
    // Encodings
    // --------------------

    // Bus access size, HSIZE style codes
    typedef enum logic [2:0] {
        WB_DSIZE_8B  = 3'b000,
        WB_DSIZE_16B = 3'b001,
        WB_DSIZE_32B = 3'b010
    } wb_dsize_e;

    // --------------------
    // Bundles
    // --------------------

    // What the bridge drives onto the bus
    // Write data is already on its byte lanes
    typedef struct packed {
        logic [`DMEM_WB_DATA_W-1:0] addr;
        logic                       we;
        logic [`DMEM_WB_DATA_W-1:0] dat;
        logic [`DMEM_WB_SEL_W-1:0]  sel;
    } wb_req_s;

    // Needed again when the read data comes back
    typedef struct packed {
        wb_dsize_e              size;
        logic [WB_OFFS_W-1:0]   offset;
    } resp_ctx_s;

    // One slot of the request FIFO
    typedef struct packed {
        wb_req_s    req;
        resp_ctx_s  ctx;
    } wb_entry_s;

endpackage

// File: logic/dmem_req_pack.sv
// --------------------
// Request packer
// Turns a core request into a lane-placed Wishbone FIFO entry
// --------------------
`timescale 1ns/1ps
`include "dmem_wb_settings.svh"

module dmem_req_pack (
    input  dmem_core_pkg::dmem_req_s dmem_req_i,
    output dmem_wb_pkg::wb_entry_s   entry_o
);
    import dmem_core_pkg::*;
    import dmem_wb_pkg::*;

    // Bits per byte lane
    localparam int LANE_W = `DMEM_WB_DATA_W / `DMEM_WB_SEL_W;

    wb_dsize_e                  size;
    logic [WB_OFFS_W-1:0]       offset;
    logic [`DMEM_WB_DATA_W-1:0] lane_data;
    logic [`DMEM_WB_SEL_W-1:0]  lane_sel;

    // --------------------
    // Width conversion
    // --------------------

    // Core width to bus size
    // Reserved width code falls back to a word
    function automatic wb_dsize_e conv_size(input mem_width_e width);
        wb_dsize_e res;
        case (width)
            MEM_WIDTH_BYTE: begin
                res = WB_DSIZE_8B;
            end
            MEM_WIDTH_HWORD: begin
                res = WB_DSIZE_16B;
            end
            default: begin
                res = WB_DSIZE_32B;
            end
        endcase
        return res;
    endfunction

    assign size   = conv_size(dmem_req_i.width);
    // Byte offset inside the bus word
    assign offset = dmem_req_i.addr[WB_OFFS_W-1:0];

    // --------------------
    // Lane placement
    // --------------------

    // Start with data and mask at lane 0, then shift both by the offset
    always_comb begin
        lane_data = '0;
        lane_sel  = '0;
        case (size)
            WB_DSIZE_8B: begin
                lane_data[LANE_W-1:0] = dmem_req_i.wdata[LANE_W-1:0];
                lane_sel[0]           = 1'b1;
            end
            WB_DSIZE_16B: begin
                lane_data[2*LANE_W-1:0] = dmem_req_i.wdata[2*LANE_W-1:0];
                lane_sel[1:0]           = 2'b11;
            end
            default: begin
                lane_data = dmem_req_i.wdata;
                lane_sel  = '1;
            end
        endcase
        // Word stays put, the full mask must not be shifted out
        if (size != WB_DSIZE_32B) begin
            lane_data = lane_data << (offset * LANE_W);
            lane_sel  = lane_sel << offset;
        end
    end

    // --------------------
    // Entry assembly
    // --------------------

    // Full address goes out, the slave decodes the word itself
    assign entry_o.req.addr   = dmem_req_i.addr;
    assign entry_o.req.we     = (dmem_req_i.cmd == MEM_CMD_WR);
    assign entry_o.req.dat    = lane_data;
    assign entry_o.req.sel    = lane_sel;
    // Kept for read-lane extraction on acknowledge
    assign entry_o.ctx.size   = size;
    assign entry_o.ctx.offset = offset;

    // Halfword on an odd byte would straddle a lane pair
    a_hword_aligned: assert final (
        !((dmem_req_i.width === MEM_WIDTH_HWORD) && (dmem_req_i.addr[0] === 1'b1))
    ) else $error("dmem_req_pack: halfword request at odd address %h", dmem_req_i.addr);

endmodule

// File: logic/dmem_req_fifo.sv
// --------------------
// Request FIFO
// Circular buffer of bus requests, head drives the Wishbone side
// --------------------
`timescale 1ns/1ps
`include "dmem_wb_settings.svh"

module dmem_req_fifo #(
    parameter int DEPTH = `DMEM_WB_FIFO_DEPTH
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    push_i,
    input  dmem_wb_pkg::wb_entry_s  entry_i,
    input  logic                    pop_i,
    output dmem_wb_pkg::wb_entry_s  head_o,
    output logic                    full_o,
    output logic                    empty_o
);
    import dmem_wb_pkg::*;

    // Pointer needs at least one bit even for a single slot
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    wb_entry_s          mem_q [DEPTH];
    logic [PTR_W-1:0]   wr_ptr_q;
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [CNT_W-1:0]   count_q;
    logic               do_push;
    logic               do_pop;

    // Wrap at DEPTH, not at a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] res;
        if (ptr == PTR_W'(DEPTH - 1)) begin
            res = '0;
        end else begin
            res = ptr + 1'b1;
        end
        return res;
    endfunction

    // --------------------
    // Flags and qualified strobes
    // --------------------
    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign empty_o = (count_q == '0);

    // Acceptance is decided here only
    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;

    // --------------------
    // Control state
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            // Simultaneous push and pop leave the count alone
            case ({do_push, do_pop})
                2'b10: count_q <= count_q + 1'b1;
                2'b01: count_q <= count_q - 1'b1;
                default: begin
                end
            endcase
        end
    end

    // Storage, written at the tail
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= entry_i;
        end
    end

    // Head visible one cycle after the write
    assign head_o = mem_q[rd_ptr_q];

    // --------------------
    // Checks
    // --------------------

    // Slave must not acknowledge without a strobe
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        pop_i |-> !empty_o)
        else $error("dmem_req_fifo: pop while empty");

    // Bus request holds until acknowledged
    a_head_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (!empty_o && !pop_i) |=> $stable(head_o))
        else $error("dmem_req_fifo: head changed without pop");

endmodule

// File: logic/dmem_resp_align.sv
// --------------------
// Response aligner
// Registers the bus reply and moves the addressed lanes down to bit 0
// --------------------
`timescale 1ns/1ps
`include "dmem_wb_settings.svh"

module dmem_resp_align (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        wb_ack_i,
    input  logic                        wb_err_i,
    input  logic [`DMEM_WB_DATA_W-1:0]  wb_dat_i,
    input  dmem_wb_pkg::resp_ctx_s      ctx_i,
    output logic [`DMEM_WB_DATA_W-1:0]  dmem_rdata_o,
    output dmem_core_pkg::mem_resp_e    dmem_resp_o
);
    import dmem_core_pkg::*;
    import dmem_wb_pkg::*;

    // Bits per byte lane
    localparam int LANE_W = `DMEM_WB_DATA_W / `DMEM_WB_SEL_W;

    logic                       valid_q;
    logic                       err_q;
    resp_ctx_s                  ctx_q;
    logic [`DMEM_WB_DATA_W-1:0] data_q;
    logic [`DMEM_WB_DATA_W-1:0] shifted;

    // --------------------
    // Response register
    // --------------------

    // One-cycle pulse per acknowledge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= wb_ack_i;
        end
    end

    // Payload follows the head entry that was just acknowledged
    always_ff @(posedge clk) begin
        if (wb_ack_i) begin
            err_q  <= wb_err_i;
            ctx_q  <= ctx_i;
            data_q <= wb_dat_i;
        end
    end

    // --------------------
    // Read-lane extraction
    // --------------------

    // Addressed byte ends up in the low lane
    assign shifted = data_q >> (ctx_q.offset * LANE_W);

    // Lanes above the access width read as zero
    always_comb begin
        dmem_rdata_o = '0;
        case (ctx_q.size)
            WB_DSIZE_8B: begin
                dmem_rdata_o[LANE_W-1:0] = shifted[LANE_W-1:0];
            end
            WB_DSIZE_16B: begin
                dmem_rdata_o[2*LANE_W-1:0] = shifted[2*LANE_W-1:0];
            end
            default: begin
                dmem_rdata_o = data_q;
            end
        endcase
    end

    // Three-valued core response
    always_comb begin
        if (!valid_q) begin
            dmem_resp_o = MEM_RESP_NOTRDY;
        end else if (err_q) begin
            dmem_resp_o = MEM_RESP_RDY_ER;
        end else begin
            dmem_resp_o = MEM_RESP_RDY_OK;
        end
    end

    // Back-to-back ready only with back-to-back acknowledges
    a_resp_single: assert property (@(posedge clk) disable iff (!rst_n)
        ((dmem_resp_o != MEM_RESP_NOTRDY) && !wb_ack_i) |=> (dmem_resp_o == MEM_RESP_NOTRDY))
        else $error("dmem_resp_align: response held without acknowledge");

endmodule

// File: logic/dmem_wb_bridge.sv
// --------------------
// Data-memory to Wishbone bridge
// Packer, two-entry request FIFO and registered response path
// --------------------
`timescale 1ns/1ps
`include "dmem_wb_settings.svh"

module dmem_wb_bridge (
    input  logic                        clk,
    input  logic                        rst_n,

    // Core data-memory port
    input  logic                        dmem_req_valid_i,
    input  dmem_core_pkg::dmem_req_s    dmem_req_i,
    output logic                        dmem_req_ack_o,
    output logic [`DMEM_WB_DATA_W-1:0]  dmem_rdata_o,
    output dmem_core_pkg::mem_resp_e    dmem_resp_o,

    // Wishbone master side
    output logic                        wb_stb_o,
    output dmem_wb_pkg::wb_req_s        wb_req_o,
    input  logic [`DMEM_WB_DATA_W-1:0]  wb_dat_i,
    input  logic                        wb_ack_i,
    input  logic                        wb_err_i
);
    import dmem_wb_pkg::*;

    wb_entry_s  pack_entry;
    wb_entry_s  head_entry;
    logic       fifo_full;
    logic       fifo_empty;

    // --------------------
    // Request path
    // --------------------

    // Same-cycle conversion of the core request
    dmem_req_pack i_dmem_req_pack (
        .dmem_req_i (dmem_req_i),
        .entry_o    (pack_entry)
    );

    // Push on valid, FIFO drops it when full
    // Pop on every acknowledge of the head
    dmem_req_fifo #(
        .DEPTH (`DMEM_WB_FIFO_DEPTH)
    ) i_dmem_req_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .push_i  (dmem_req_valid_i),
        .entry_i (pack_entry),
        .pop_i   (wb_ack_i),
        .head_o  (head_entry),
        .full_o  (fifo_full),
        .empty_o (fifo_empty)
    );

    // Core may offer while there is room
    assign dmem_req_ack_o = ~fifo_full;

    // Head stays on the bus until acknowledged
    assign wb_stb_o = ~fifo_empty;
    assign wb_req_o = head_entry.req;

    // --------------------
    // Response path
    // --------------------

    // Context comes from the head being acknowledged
    dmem_resp_align i_dmem_resp_align (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb_ack_i     (wb_ack_i),
        .wb_err_i     (wb_err_i),
        .wb_dat_i     (wb_dat_i),
        .ctx_i        (head_entry.ctx),
        .dmem_rdata_o (dmem_rdata_o),
        .dmem_resp_o  (dmem_resp_o)
    );

endmodule

// File: bench/dmem_wb_tests.svh
// --------------------
// Directed tests for the bridge
// --------------------

// Offer one request and record what the core should get back
task automatic send_req(input mem_cmd_e cmd, input mem_width_e width,
                        input logic [31:0] addr, input logic [31:0] wdata);
    int          n;
    logic [31:0] word;
    logic [31:0] mask;
    logic [31:0] repl;
    exp_resp_s   e;
    dmem_req_valid_i = 1'b1;
    dmem_req_i       = '{cmd: cmd, width: width, addr: addr, wdata: wdata};
    n = 0;
    while (dmem_req_ack_o !== 1'b1) begin
        @(posedge clk);
        #DRIVE_DLY;
        n++;
        assert (n < TIMEOUT) else report_failure("request never accepted by the bridge");
    end
    word = ref_mem.exists(addr[31:2]) ? ref_mem[addr[31:2]] : fill_word(addr[31:2]);
    // Low-lane mask and write data copied onto every lane
    case (width)
        MEM_WIDTH_BYTE: begin
            mask = 32'h0000_00ff;
            repl = {4{wdata[7:0]}};
        end
        MEM_WIDTH_HWORD: begin
            mask = 32'h0000_ffff;
            repl = {2{wdata[15:0]}};
        end
        default: begin
            mask = 32'hffff_ffff;
            repl = wdata;
        end
    endcase
    e.resp = addr[31] ? MEM_RESP_RDY_ER : MEM_RESP_RDY_OK;
    e.chk  = (cmd == MEM_CMD_RD) && !addr[31];
    e.data = (word >> (8 * addr[1:0])) & mask;
    exp_q.push_back(e);
    // Errored writes leave memory alone
    if (cmd == MEM_CMD_WR && !addr[31]) begin
        mask = mask << (8 * addr[1:0]);
        ref_mem[addr[31:2]] = (word & ~mask) | (repl & mask);
    end
    @(posedge clk);
    #DRIVE_DLY;
    dmem_req_valid_i = 1'b0;
endtask

// Wait until every issued request has answered
task automatic drain_responses();
    int n;
    n = 0;
    while (exp_q.size() != 0) begin
        @(posedge clk);
        #DRIVE_DLY;
        n++;
        assert (n < TIMEOUT) else report_failure("response missing after bus activity");
    end
endtask

// Write cycle as seen by the slave
// Only selected lanes are compared
task automatic check_bus(input logic [3:0] sel_exp, input logic [31:0] dat_exp);
    logic [31:0] lanes;
    lanes = {{8{sel_exp[3]}}, {8{sel_exp[2]}}, {8{sel_exp[1]}}, {8{sel_exp[0]}}};
    check_value("wb_req_o.we", last_req.we, 1'b1);
    check_value("wb_req_o.sel", last_req.sel, sel_exp);
    check_value("wb_req_o.dat", last_req.dat & lanes, dat_exp & lanes);
endtask

// Idle outputs right after reset
task automatic reset_state();
    check_value("wb_stb_o", wb_stb_o, 1'b0);
    check_value("dmem_resp_o", dmem_resp_o, MEM_RESP_NOTRDY);
    check_value("dmem_req_ack_o", dmem_req_ack_o, 1'b1);
endtask

// Full word out and back
task automatic word_round_trip();
    send_req(MEM_CMD_WR, MEM_WIDTH_WORD, 32'h0000_0100, 32'hcafe_f00d);
    drain_responses();
    check_bus(4'b1111, 32'hcafe_f00d);
    send_req(MEM_CMD_RD, MEM_WIDTH_WORD, 32'h0000_0100, 32'h0);
    drain_responses();
endtask

task automatic lane_placement();
    logic [31:0] wd;
    // One byte per lane
    for (int off = 0; off < 4; off++) begin
        wd = 32'h5500_0011 * (off + 1);
        send_req(MEM_CMD_WR, MEM_WIDTH_BYTE, 32'h0000_0200 + off, wd);
        drain_responses();
        check_bus(4'b0001 << off, {4{wd[7:0]}});
    end
    // Lower and upper halfword
    for (int off = 0; off < 4; off += 2) begin
        wd = 32'h0000_beef + off;
        send_req(MEM_CMD_WR, MEM_WIDTH_HWORD, 32'h0000_0300 + off, wd);
        drain_responses();
        check_bus(4'b0011 << off, {2{wd[15:0]}});
    end
    // Merged words then narrow reads at every legal offset
    send_req(MEM_CMD_RD, MEM_WIDTH_WORD, 32'h0000_0200, 32'h0);
    send_req(MEM_CMD_RD, MEM_WIDTH_WORD, 32'h0000_0300, 32'h0);
    for (int off = 0; off < 4; off++) begin
        send_req(MEM_CMD_RD, MEM_WIDTH_BYTE, 32'h0000_0300 + off, 32'h0);
    end
    send_req(MEM_CMD_RD, MEM_WIDTH_HWORD, 32'h0000_0200, 32'h0);
    send_req(MEM_CMD_RD, MEM_WIDTH_HWORD, 32'h0000_0202, 32'h0);
    drain_responses();
endtask

// Bit 31 set on a write and a narrow read
task automatic error_response();
    send_req(MEM_CMD_WR, MEM_WIDTH_WORD, 32'h8000_0040, 32'h1234_5678);
    send_req(MEM_CMD_RD, MEM_WIDTH_BYTE, 32'h8000_0041, 32'h0);
    // Bridge keeps working after errors
    send_req(MEM_CMD_WR, MEM_WIDTH_WORD, 32'h0000_0040, 32'h0bad_f00d);
    send_req(MEM_CMD_RD, MEM_WIDTH_WORD, 32'h0000_0040, 32'h0);
    drain_responses();
endtask

// Back-to-back offers with mixed widths and one errored access
task automatic stream_backpressure();
    mem_width_e  w;
    logic [31:0] addr;
    for (int i = 0; i < 24; i++) begin
        w    = mem_width_e'(i % 3);
        addr = 32'h0000_0400 + ((i % 5) << 2);
        if (w == MEM_WIDTH_BYTE) addr += i % 4;
        if (w == MEM_WIDTH_HWORD) addr += i & 2;
        if (i == 10) addr[31] = 1'b1;
        send_req((i % 4 < 2) ? MEM_CMD_WR : MEM_CMD_RD, w, addr,
                 {i[7:0], ~i[7:0], i[7:0] + 8'h5a, 8'hc3});
    end
    drain_responses();
    assert (saw_full) else report_failure("request FIFO never filled under back-to-back offers");
endtask

// File: bench/dmem_wb_tb.sv
// --------------------
// Bridge testbench
// Wishbone slave memory with wait states, response monitor, directed tests
// --------------------
`timescale 1ns/1ps
`include "dmem_wb_settings.svh"

module dmem_wb_tb;
    import dmem_core_pkg::*;
    import dmem_wb_pkg::*;

    localparam int TIMEOUT   = 60;
    localparam int DRIVE_DLY = 1;

    // Expected core response
    // Data is checked on good reads only
    typedef struct {
        mem_resp_e                  resp;
        logic                       chk;
        logic [`DMEM_WB_DATA_W-1:0] data;
    } exp_resp_s;

    logic                       clk;
    logic                       rst_n;
    logic                       dmem_req_valid_i;
    dmem_req_s                  dmem_req_i;
    logic                       dmem_req_ack_o;
    logic [`DMEM_WB_DATA_W-1:0] dmem_rdata_o;
    mem_resp_e                  dmem_resp_o;
    logic                       wb_stb_o;
    wb_req_s                    wb_req_o;
    logic [`DMEM_WB_DATA_W-1:0] wb_dat_i;
    logic                       wb_ack_i;
    logic                       wb_err_i;

    // Slave memory and reference copy indexed by word address
    logic [31:0] slave_mem [logic [29:0]];
    logic [31:0] ref_mem [logic [29:0]];
    wb_req_s     last_req;
    exp_resp_s   exp_q [$];
    int          acc_cnt;
    int          bus_cnt;
    logic        saw_full;

    dmem_wb_bridge i_dmem_wb_bridge (
        .clk              (clk),
        .rst_n            (rst_n),
        .dmem_req_valid_i (dmem_req_valid_i),
        .dmem_req_i       (dmem_req_i),
        .dmem_req_ack_o   (dmem_req_ack_o),
        .dmem_rdata_o     (dmem_rdata_o),
        .dmem_resp_o      (dmem_resp_o),
        .wb_stb_o         (wb_stb_o),
        .wb_req_o         (wb_req_o),
        .wb_dat_i         (wb_dat_i),
        .wb_ack_i         (wb_ack_i),
        .wb_err_i         (wb_err_i)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Unwritten words read back a value tied to every address bit
    function automatic logic [31:0] fill_word(input logic [29:0] idx);
        return {idx, 2'b01} ^ 32'ha5c3_0f96;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "stopped at first failing check");
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
            else report_failure($sformatf("error: %s got %h expected %h", name, got, exp));
    endtask

    // --------------------
    // Slave model
    // --------------------

    // Ack after 0 to 3 wait states
    // Address bit 31 answers with error
    initial begin
        int          wait_left;
        logic        busy;
        logic [29:0] idx;
        logic [31:0] word;
        void'($urandom(32'hf77c371e));
        wb_ack_i  = 1'b0;
        wb_err_i  = 1'b0;
        wb_dat_i  = '0;
        busy      = 1'b0;
        wait_left = 0;
        forever begin
            @(posedge clk);
            #DRIVE_DLY;
            // Previous ack popped the head at this edge
            wb_ack_i = 1'b0;
            wb_err_i = 1'b0;
            if (wb_stb_o === 1'b1) begin
                if (!busy) begin
                    busy      = 1'b1;
                    wait_left = $urandom % 4;
                end
                if (wait_left == 0) begin
                    idx  = wb_req_o.addr[31:2];
                    word = slave_mem.exists(idx) ? slave_mem[idx] : fill_word(idx);
                    if (wb_req_o.we && !wb_req_o.addr[31]) begin
                        for (int b = 0; b < 4; b++) begin
                            if (wb_req_o.sel[b]) word[8*b +: 8] = wb_req_o.dat[8*b +: 8];
                        end
                        slave_mem[idx] = word;
                    end
                    wb_dat_i = word;
                    wb_ack_i = 1'b1;
                    wb_err_i = wb_req_o.addr[31];
                    last_req = wb_req_o;
                    busy     = 1'b0;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    // --------------------
    // Monitor
    // --------------------

    // Sampled at negedge when inputs and outputs have settled
    always @(negedge clk) begin
        exp_resp_s e;
        if (rst_n) begin
            // FIFO occupancy is accepted minus acknowledged
            check_value("dmem_req_ack_o", dmem_req_ack_o, (acc_cnt - bus_cnt) < 2);
            check_value("wb_stb_o", wb_stb_o, (acc_cnt - bus_cnt) != 0);
            if (!dmem_req_ack_o) saw_full = 1'b1;
            if (dmem_req_valid_i && dmem_req_ack_o) acc_cnt++;
            if (wb_ack_i) bus_cnt++;
            if (dmem_resp_o !== MEM_RESP_NOTRDY) begin
                assert (exp_q.size() > 0)
                    else report_failure("core response seen with no request outstanding");
                e = exp_q.pop_front();
                check_value("dmem_resp_o", dmem_resp_o, e.resp);
                if (e.chk) check_value("dmem_rdata_o", dmem_rdata_o, e.data);
            end
        end
    end

    `include "dmem_wb_tests.svh"

    initial begin
        acc_cnt          = 0;
        bus_cnt          = 0;
        saw_full         = 1'b0;
        rst_n            = 1'b0;
        dmem_req_valid_i = 1'b0;
        dmem_req_i       = '0;
        repeat (2) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        reset_state();
        word_round_trip();
        lane_placement();
        error_response();
        stream_backpressure();
        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+logic
+incdir+bench
logic/dmem_core_pkg.sv
logic/dmem_wb_pkg.sv
logic/dmem_req_pack.sv
logic/dmem_req_fifo.sv
logic/dmem_resp_align.sv
logic/dmem_wb_bridge.sv
bench/dmem_wb_tb.sv
